// File: vlog.f
hdl/bitsyncPkg.sv
hdl/axiLiteRegBridge.sv
hdl/bitsyncTopRegs.sv
hdl/lockDetector.sv
hdl/dacMonitorMux.sv
hdl/bitsyncSubsystem.sv
testbench/busClkGen.sv
testbench/bitsyncTb.sv

// File: testbench/bitsyncTb.sv
// Self-checking testbench for bitsyncSubsystem; stops at the first mismatch
// Lock parameters below are passed to the DUT; select 2 of the DAC mux is not exercised
`timescale 1ns/1ps

module bitsyncTb;
    import bitsyncPkg::*;

    localparam int LOCK_COUNT   = 8;
    localparam int UNLOCK_COUNT = 4;
    localparam int PHASE_TOL    = 16;
    localparam int RAND_WRITES  = 40;
    localparam int LOCK_SEQS    = 12;
    localparam int MON_CYCLES   = 24;
    localparam int TXN_COUNT    = 2 * RAND_WRITES + LOCK_SEQS + 40;
    localparam int LOCK_TEST_NS = (LOCK_SEQS * 17 + LOCK_COUNT + MON_CYCLES + 20) * 4;

    logic busClk, rst;
    logic awValid, awReady, wValid, wReady, bValid, bReady;
    logic arValid, arReady, rValid, rReady;
    logic [12:0] awAddr, arAddr;
    logic [31:0] wData, rData;
    logic [3:0] wStrb;
    logic [1:0] bResp, rResp;
    logic signed [7:0] ch0Sample, ch0PhaseErr, ch1Sample, ch1PhaseErr;
    logic ch0SymbolValid, ch1SymbolValid;
    logic [7:0] ch0Dac0, ch0Dac1, ch0Dac2, ch1Dac0, ch1Dac1, ch1Dac2;
    afeCtrlT ch0AfeCtrl, ch1AfeCtrl;

    logic [31:0] lfsrState;
    logic [31:0] modelRegs [0:4];   // Indexed by offset / 4
    logic [8:0] lockSt0, lockSt1;   // {locked, run count}
    logic monCheckOn, monArmed;
    logic signed [7:0] prevSmp0, prevErr0, prevSmp1, prevErr1;

    busClkGen uClk (.busClk, .rst);

    bitsyncSubsystem #(.LOCK_COUNT(LOCK_COUNT), .UNLOCK_COUNT(UNLOCK_COUNT),
                       .PHASE_TOL(PHASE_TOL)) DUT (.*);

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] d,
                                               input logic [3:0] strb, input logic [31:0] fields);
        logic [31:0] m;
        m = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}} & fields;
        return (old & ~m) | (d & m);
    endfunction

    function automatic logic [31:0] expectedRead(input logic [12:0] addr);
        case (addr)
            BS_TOP_CONTROL:     return modelRegs[0];
            BS_TOP_CH0_CONTROL: return modelRegs[1];
            BS_TOP_CH1_CONTROL: return modelRegs[2];
            BS_TOP_STATUS:      return {30'h0, lockSt1[8], lockSt0[8]};
            BS_TOP_DC_GAINS:    return modelRegs[4];
            default:            return 32'h0;
        endcase
    endfunction

    // A symbol that disagrees with the current state extends the run
    function automatic logic [8:0] lockRef(input logic [8:0] st, input logic signed [7:0] err);
        int mag;
        int run;
        logic lk;
        logic good;
        mag  = (err < 0) ? -int'(err) : int'(err);
        good = mag < PHASE_TOL;
        lk   = st[8];
        run  = int'(st[7:0]);
        if (good != lk) begin
            run = run + 1;
            if (run == (lk ? UNLOCK_COUNT : LOCK_COUNT)) begin
                lk  = !lk;
                run = 0;
            end
        end else begin
            run = 0;
        end
        return {lk, 8'(run)};
    endfunction

    function automatic logic [7:0] refDac(input logic [3:0] sel, input logic [7:0] smp,
                                          input logic [7:0] err, input logic lk);
        case (sel)
            4'd0:    return smp;
            4'd1:    return err;
            4'd3:    return lk ? 8'hFF : 8'h00;
            default: return 8'h00;
        endcase
    endfunction

    // Higher bias gives more symbols inside tolerance
    function automatic logic signed [7:0] phaseSample(input int bias);
        int mag;
        if (int'(randomBits(2)) <= bias)
            mag = int'(randomBits(8)) % PHASE_TOL;
        else if (randomBits(3) == 0)
            return -8'sd128;
        else
            mag = PHASE_TOL + int'(randomBits(6));
        return (randomBits(1) != 0) ? 8'(-mag) : 8'(mag);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    task automatic nextCycle();
        @(posedge busClk);
        #1;
    endtask

    task automatic updateModel(input logic [12:0] addr, input logic [31:0] d,
                               input logic [3:0] strb);
        bitsyncModeT m;
        case (addr)
            BS_TOP_CONTROL:     modelRegs[0] = mergeBytes(modelRegs[0], d, strb, 32'h0000_0003);
            BS_TOP_CH0_CONTROL: modelRegs[1] = mergeBytes(modelRegs[1], d, strb, 32'hE00F_0F0F);
            BS_TOP_CH1_CONTROL: modelRegs[2] = mergeBytes(modelRegs[2], d, strb, 32'hE00F_0F0F);
            BS_TOP_DC_GAINS:    modelRegs[4] = mergeBytes(modelRegs[4], d, strb, 32'h0000_1F1F);
            default: ;
        endcase
        m = bitsyncModeT'(modelRegs[0][1:0]);
        if (!(m == MODE_CH0 || m == MODE_BOTH))
            lockSt0 = '0;   // Disabled detector drops lock and count
        if (!(m == MODE_CH1 || m == MODE_BOTH))
            lockSt1 = '0;
    endtask

    // order 0 sends aw and w together, 1 aw first, 2 w first
    task automatic axiWrite(input logic [12:0] addr, input logic [31:0] d,
                            input logic [3:0] strb, input int order, input int stall);
        logic awDone;
        logic wDone;
        logic awFire;
        logic wFire;
        awDone  = 1'b0;
        wDone   = 1'b0;
        awAddr  = addr;
        wData   = d;
        wStrb   = strb;
        awValid = (order != 2);
        wValid  = (order != 1);
        while (!(awDone && wDone)) begin
            awFire = awValid && awReady;
            wFire  = wValid && wReady;
            nextCycle();
            if (awFire) begin
                awValid = 1'b0;
                awDone  = 1'b1;
            end
            if (wFire) begin
                wValid = 1'b0;
                wDone  = 1'b1;
            end
            if (awDone && !wDone)
                wValid = 1'b1;
            if (wDone && !awDone)
                awValid = 1'b1;
        end
        bReady = (stall == 0);
        while (!(bValid && bReady)) begin
            nextCycle();
            if (bValid && stall > 0)
                stall--;
            bReady = (stall == 0);
        end
        check("bResp", bResp, 32'h0);
        updateModel(addr, d, strb);
        nextCycle();
    endtask

    task automatic axiRead(input logic [12:0] addr, input int stall);
        arAddr  = addr;
        arValid = 1'b1;
        while (!arReady)
            nextCycle();
        nextCycle();
        arValid = 1'b0;
        rReady  = (stall == 0);
        while (!(rValid && rReady)) begin
            nextCycle();
            if (rValid && stall > 0)
                stall--;
            rReady = (stall == 0);
        end
        check("rResp", rResp, 32'h0);
        check($sformatf("rData[%h]", addr), rData, expectedRead(addr));
        nextCycle();
    endtask

    task automatic readAll();
        for (int a = 0; a <= 5; a++)
            axiRead(13'(a * 4), 0);   // 0x014 is unmapped
    endtask

    // DAC outputs follow the inputs seen at the previous edge
    always @(posedge busClk) begin
        prevSmp0 <= ch0Sample;
        prevErr0 <= ch0PhaseErr;
        prevSmp1 <= ch1Sample;
        prevErr1 <= ch1PhaseErr;
        monArmed <= monCheckOn;
    end

    always @(negedge busClk) begin
        if (monArmed === 1'b1) begin
            check("ch0Dac0", ch0Dac0, refDac(modelRegs[1][3:0], prevSmp0, prevErr0, lockSt0[8]));
            check("ch0Dac1", ch0Dac1, refDac(modelRegs[1][11:8], prevSmp0, prevErr0, lockSt0[8]));
            check("ch0Dac2", ch0Dac2, refDac(modelRegs[1][19:16], prevSmp0, prevErr0, lockSt0[8]));
            check("ch1Dac0", ch1Dac0, refDac(modelRegs[2][3:0], prevSmp1, prevErr1, lockSt1[8]));
            check("ch1Dac1", ch1Dac1, refDac(modelRegs[2][11:8], prevSmp1, prevErr1, lockSt1[8]));
            check("ch1Dac2", ch1Dac2, refDac(modelRegs[2][19:16], prevSmp1, prevErr1, lockSt1[8]));
        end
    end

    initial begin
        #(TXN_COUNT * 40 + LOCK_TEST_NS);
        $display("Timeout: the DUT did not complete the test sequence in time");
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int sel;
        int order;
        int stall;
        int bias0;
        int bias1;
        int len;
        logic [12:0] addr;
        logic [31:0] data;
        logic [3:0] strb;
        logic [3:0] bigSel;
        logic [2:0] afe;
        awValid = 1'b0;
        awAddr = '0;
        wValid = 1'b0;
        wData = '0;
        wStrb = '0;
        bReady = 1'b1;
        arValid = 1'b0;
        arAddr = '0;
        rReady = 1'b1;
        ch0Sample = '0;
        ch0PhaseErr = '0;
        ch0SymbolValid = 1'b0;
        ch1Sample = '0;
        ch1PhaseErr = '0;
        ch1SymbolValid = 1'b0;
        lfsrState = 32'hf74f_c579;
        for (int i = 0; i < 5; i++)
            modelRegs[i] = '0;
        lockSt0 = '0;
        lockSt1 = '0;
        monCheckOn = 1'b0;
        @(negedge rst);
        nextCycle();

        check("bValid", bValid, 32'h0);
        check("rValid", rValid, 32'h0);
        readAll();

        // Each random byte-strobed write is read back
        for (int i = 0; i < RAND_WRITES; i++) begin
            sel = int'(randomBits(3));
            if (sel <= 4)
                addr = 13'(sel * 4);
            else if (sel == 5)
                addr = 13'(randomBits(13));
            else
                addr = (sel == 6) ? 13'h014 : BS_TOP_STATUS;
            data  = randomBits(32);
            strb  = 4'(randomBits(4));
            order = int'(randomBits(2)) % 3;
            stall = int'(randomBits(2));
            axiWrite(addr, data, strb, order, stall);
            stall = int'(randomBits(2));
            axiRead(addr, stall);
        end
        readAll();

        // Channel ordering and longer response stalls
        axiWrite(BS_TOP_CH0_CONTROL, randomBits(32), 4'hF, 1, int'(randomBits(3)));
        axiWrite(BS_TOP_CH1_CONTROL, randomBits(32), 4'hF, 2, int'(randomBits(3)));
        axiWrite(BS_TOP_DC_GAINS, randomBits(32), 4'hF, 0, int'(randomBits(3)));
        axiRead(BS_TOP_CH0_CONTROL, int'(randomBits(3)));
        axiRead(BS_TOP_CH1_CONTROL, int'(randomBits(3)));
        axiRead(BS_TOP_DC_GAINS, int'(randomBits(3)));

        axiWrite(BS_TOP_CONTROL, 32'(MODE_BOTH), 4'h1, 0, 0);
        for (int s = 0; s < LOCK_SEQS; s++) begin
            bias0 = int'(randomBits(2));
            bias1 = int'(randomBits(2));
            len   = 1 + int'(randomBits(4));
            for (int k = 0; k < len; k++) begin
                ch0SymbolValid = (randomBits(3) != 0);
                ch0PhaseErr    = phaseSample(bias0);
                ch1SymbolValid = (randomBits(3) != 0);
                ch1PhaseErr    = phaseSample(bias1);
                if (ch0SymbolValid)
                    lockSt0 = lockRef(lockSt0, ch0PhaseErr);
                if (ch1SymbolValid)
                    lockSt1 = lockRef(lockSt1, ch1PhaseErr);
                nextCycle();
            end
            ch0SymbolValid = 1'b0;
            ch1SymbolValid = 1'b0;
            nextCycle();
            axiRead(BS_TOP_STATUS, 0);
        end
        axiWrite(BS_TOP_CONTROL, 32'(MODE_OFF), 4'h1, 0, 0);
        axiRead(BS_TOP_STATUS, 0);

        // Lock channel 0 only before the DAC checks
        axiWrite(BS_TOP_CONTROL, 32'(MODE_BOTH), 4'h1, 0, 0);
        for (int k = 0; k < LOCK_COUNT; k++) begin
            ch0SymbolValid = 1'b1;
            ch0PhaseErr    = phaseSample(3);
            lockSt0        = lockRef(lockSt0, ch0PhaseErr);
            nextCycle();
        end
        ch0SymbolValid = 1'b0;
        nextCycle();
        axiRead(BS_TOP_STATUS, 0);

        afe = 3'(randomBits(3));
        axiWrite(BS_TOP_CH0_CONTROL, {afe, 9'h0, 4'd3, 4'h0, 4'd1, 4'h0, 4'd0}, 4'hF, 0, 0);
        afe    = 3'(randomBits(3));
        bigSel = 4'(randomBits(4));
        if (bigSel < 4'd4)
            bigSel = bigSel + 4'd4;
        axiWrite(BS_TOP_CH1_CONTROL, {afe, 9'h0, 4'd1, 4'h0, 4'd3, 4'h0, bigSel}, 4'hF, 0, 0);
        axiWrite(BS_TOP_DC_GAINS, randomBits(32), 4'h3, 0, 0);
        check("ch0AfeCtrl", ch0AfeCtrl, {modelRegs[1][29], modelRegs[1][30], modelRegs[4][4:0]});
        check("ch1AfeCtrl", ch1AfeCtrl, {modelRegs[2][29], modelRegs[2][30], modelRegs[4][12:8]});

        monCheckOn = 1'b1;
        for (int k = 0; k < MON_CYCLES; k++) begin
            ch0Sample   = 8'(randomBits(8));
            ch0PhaseErr = 8'(randomBits(8));
            ch1Sample   = 8'(randomBits(8));
            ch1PhaseErr = 8'(randomBits(8));
            nextCycle();
        end
        monCheckOn = 1'b0;
        nextCycle();
        nextCycle();

        // Channel 0 is locked here, so MODE_OFF has a bit to clear
        axiWrite(BS_TOP_CONTROL, 32'(MODE_OFF), 4'h1, 0, 0);
        axiRead(BS_TOP_STATUS, 0);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: testbench/busClkGen.sv
// Free-running 4 ns bus clock; rst held high through the first three rising edges
`timescale 1ns/1ps

module busClkGen (
    output logic busClk,
    output logic rst
);
    initial begin
        busClk = 1'b0;
        forever #2 busClk = ~busClk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge busClk);
        #1 rst = 1'b0;   // Released with the other stimulus offset
    end

endmodule

// File: hdl/bitsyncSubsystem.sv
// Bitsync control plane top; the loop itself is external, phase error and samples come in
// AXI addresses are 13-bit byte addresses
`timescale 1ns/1ps

module bitsyncSubsystem #(
    parameter int LOCK_COUNT   = 8,
    parameter int UNLOCK_COUNT = 4,
    parameter int PHASE_TOL    = 16
) (
    input  logic                 busClk,
    input  logic                 rst,
    input  logic                 awValid,
    output logic                 awReady,
    input  logic [12:0]          awAddr,
    input  logic                 wValid,
    output logic                 wReady,
    input  logic [31:0]          wData,
    input  logic [3:0]           wStrb,
    output logic                 bValid,
    input  logic                 bReady,
    output logic [1:0]           bResp,
    input  logic                 arValid,
    output logic                 arReady,
    input  logic [12:0]          arAddr,
    output logic                 rValid,
    input  logic                 rReady,
    output logic [31:0]          rData,
    output logic [1:0]           rResp,
    input  logic signed [7:0]    ch0Sample,
    input  logic signed [7:0]    ch0PhaseErr,
    input  logic                 ch0SymbolValid,
    output logic [7:0]           ch0Dac0,
    output logic [7:0]           ch0Dac1,
    output logic [7:0]           ch0Dac2,
    output bitsyncPkg::afeCtrlT  ch0AfeCtrl,
    input  logic signed [7:0]    ch1Sample,
    input  logic signed [7:0]    ch1PhaseErr,
    input  logic                 ch1SymbolValid,
    output logic [7:0]           ch1Dac0,
    output logic [7:0]           ch1Dac1,
    output logic [7:0]           ch1Dac2,
    output bitsyncPkg::afeCtrlT  ch1AfeCtrl
);
    import bitsyncPkg::*;

    regReqT      regReq;
    logic [31:0] rdData;
    bitsyncModeT mode;
    chanCtrlT    ch0Ctrl;
    chanCtrlT    ch1Ctrl;
    logic        ch0Locked;
    logic        ch1Locked;
    monitorT     ch0Mon;
    monitorT     ch1Mon;

    assign ch0Mon = '{sample: ch0Sample, phaseErr: ch0PhaseErr,
                      locked: ch0Locked, symbolValid: ch0SymbolValid};
    assign ch1Mon = '{sample: ch1Sample, phaseErr: ch1PhaseErr,
                      locked: ch1Locked, symbolValid: ch1SymbolValid};

    assign ch0AfeCtrl = '{singleEnded: ch0Ctrl.singleEnded,
                          highImpedance: ch0Ctrl.highImpedance, dcGain: ch0Ctrl.dcGain};
    assign ch1AfeCtrl = '{singleEnded: ch1Ctrl.singleEnded,
                          highImpedance: ch1Ctrl.highImpedance, dcGain: ch1Ctrl.dcGain};

    axiLiteRegBridge uBridge (
        .busClk, .rst,
        .awValid, .awReady, .awAddr,
        .wValid, .wReady, .wData, .wStrb,
        .bValid, .bReady, .bResp,
        .arValid, .arReady, .arAddr,
        .rValid, .rReady, .rData, .rResp,
        .regReq, .rdData
    );

    bitsyncTopRegs uRegs (
        .busClk, .rst, .regReq, .rdData,
        .lockStatus ({ch1Locked, ch0Locked}),
        .mode, .ch0Ctrl, .ch1Ctrl
    );

    lockDetector #(.LOCK_COUNT(LOCK_COUNT), .UNLOCK_COUNT(UNLOCK_COUNT),
                   .PHASE_TOL(PHASE_TOL)) uLock0 (
        .busClk, .rst,
        .enable      (mode == MODE_CH0 || mode == MODE_BOTH),
        .symbolValid (ch0SymbolValid),
        .phaseErr    (ch0PhaseErr),
        .locked      (ch0Locked)
    );

    lockDetector #(.LOCK_COUNT(LOCK_COUNT), .UNLOCK_COUNT(UNLOCK_COUNT),
                   .PHASE_TOL(PHASE_TOL)) uLock1 (
        .busClk, .rst,
        .enable      (mode == MODE_CH1 || mode == MODE_BOTH),
        .symbolValid (ch1SymbolValid),
        .phaseErr    (ch1PhaseErr),
        .locked      (ch1Locked)
    );

    dacMonitorMux uMon0 (
        .busClk, .rst, .ctrl (ch0Ctrl), .mon (ch0Mon),
        .dac0 (ch0Dac0), .dac1 (ch0Dac1), .dac2 (ch0Dac2)
    );

    dacMonitorMux uMon1 (
        .busClk, .rst, .ctrl (ch1Ctrl), .mon (ch1Mon),
        .dac0 (ch1Dac0), .dac1 (ch1Dac1), .dac2 (ch1Dac2)
    );

endmodule

// File: hdl/dacMonitorMux.sv
// Three registered test DAC outputs for one channel, selected per DAC
// Select 2 is the DC-removed sample saturated to 8 bits; selects above 3 give zero
`timescale 1ns/1ps

module dacMonitorMux (
    input  logic                  busClk,
    input  logic                  rst,
    input  bitsyncPkg::chanCtrlT  ctrl,
    input  bitsyncPkg::monitorT   mon,
    output logic [7:0]            dac0,
    output logic [7:0]            dac1,
    output logic [7:0]            dac2
);
    import bitsyncPkg::*;

    logic signed [10:0] dcAcc;     // DC estimate scaled by 8
    logic signed [10:0] dcNext;
    logic signed [7:0]  dcEst;
    logic signed [8:0]  diff;
    logic signed [7:0]  dcRemoved;

    assign dcEst = 8'(dcAcc >>> 3);

    // est += (sample - est) / 8 with 3 extra fraction bits
    assign dcNext = dcAcc + 11'(mon.sample) - (dcAcc >>> 3);

    assign diff = 9'(mon.sample) - 9'(dcEst);
    always_comb begin
        if (diff > 9'sd127)
            dcRemoved = 8'sd127;
        else if (diff < -9'sd128)
            dcRemoved = -8'sd128;
        else
            dcRemoved = diff[7:0];
    end

    function automatic logic [7:0] pickSource(input logic [3:0] sel);
        case (sel)
            4'd0:    return mon.sample;
            4'd1:    return mon.phaseErr;
            4'd2:    return ctrl.dcRemovalEnable ? dcRemoved : mon.sample;
            4'd3:    return {8{mon.locked}};
            default: return 8'h00;
        endcase
    endfunction

    always_ff @(posedge busClk) begin
        if (rst || !ctrl.dcRemovalEnable)
            dcAcc <= '0;
        else if (mon.symbolValid)
            dcAcc <= dcNext;
    end

    always_ff @(posedge busClk) begin
        if (rst) begin
            dac0 <= 8'h00;
            dac1 <= 8'h00;
            dac2 <= 8'h00;
        end else begin
            dac0 <= pickSource(ctrl.dac0Select);
            dac1 <= pickSource(ctrl.dac1Select);
            dac2 <= pickSource(ctrl.dac2Select);
        end
    end

endmodule

// File: hdl/lockDetector.sv
// Counted hysteresis on |phaseErr|; a symbol is good when the magnitude is below PHASE_TOL
`timescale 1ns/1ps

module lockDetector #(
    parameter int LOCK_COUNT   = 8,
    parameter int UNLOCK_COUNT = 4,
    parameter int PHASE_TOL    = 16
) (
    input  logic              busClk,
    input  logic              rst,
    input  logic              enable,
    input  logic              symbolValid,
    input  logic signed [7:0] phaseErr,
    output logic              locked
);
    localparam int MAX_COUNT = (LOCK_COUNT > UNLOCK_COUNT) ? LOCK_COUNT : UNLOCK_COUNT;
    localparam int CNT_W     = $clog2(MAX_COUNT + 1);

    logic signed [8:0] errExt;
    logic [8:0]        errMag;
    logic              good;
    logic [CNT_W-1:0]  run;    // Good run while unlocked, bad run while locked

    assign errExt = phaseErr;
    assign errMag = errExt[8] ? -errExt : errExt;   // 9 bits so -128 stays positive
    assign good   = errMag < PHASE_TOL;

    always_ff @(posedge busClk) begin
        if (rst || !enable) begin
            locked <= 1'b0;
            run    <= '0;
        end else if (symbolValid) begin
            if (!locked) begin
                if (!good) begin
                    run <= '0;
                end else if (run == CNT_W'(LOCK_COUNT - 1)) begin
                    locked <= 1'b1;
                    run    <= '0;
                end else begin
                    run <= run + 1'b1;
                end
            end else begin
                if (good) begin
                    run <= '0;
                end else if (run == CNT_W'(UNLOCK_COUNT - 1)) begin
                    locked <= 1'b0;
                    run    <= '0;
                end else begin
                    run <= run + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/bitsyncTopRegs.sv
// Control and status registers; byte strobes select which fields a write touches
// Read data is combinational and zero outside a read strobe or for unmapped addresses
`timescale 1ns/1ps

module bitsyncTopRegs (
    input  logic                     busClk,
    input  logic                     rst,
    input  bitsyncPkg::regReqT       regReq,
    output logic [31:0]              rdData,
    input  logic [1:0]               lockStatus,
    output bitsyncPkg::bitsyncModeT  mode,
    output bitsyncPkg::chanCtrlT     ch0Ctrl,
    output bitsyncPkg::chanCtrlT     ch1Ctrl
);
    import bitsyncPkg::*;

    // Merge one write into a channel's CONTROL fields
    function automatic chanCtrlT mergeChan(input chanCtrlT cur, input logic [31:0] d,
                                           input logic [3:0] strb);
        chanCtrlT nxt;
        nxt = cur;
        if (strb[0])
            nxt.dac0Select = d[3:0];
        if (strb[1])
            nxt.dac1Select = d[11:8];
        if (strb[2])
            nxt.dac2Select = d[19:16];
        if (strb[3]) begin
            nxt.singleEnded     = d[29];
            nxt.highImpedance   = d[30];
            nxt.dcRemovalEnable = d[31];
        end
        return nxt;
    endfunction

    function automatic logic [31:0] chanWord(input chanCtrlT c);
        return {c.dcRemovalEnable, c.highImpedance, c.singleEnded, 5'b0,
                4'h0, c.dac2Select,
                4'h0, c.dac1Select,
                4'h0, c.dac0Select};
    endfunction

    always_ff @(posedge busClk) begin
        if (rst) begin
            mode    <= MODE_OFF;
            ch0Ctrl <= '0;
            ch1Ctrl <= '0;
        end else if (regReq.wrEn) begin
            case (regReq.addr)
                BS_TOP_CONTROL: begin
                    if (regReq.wstrb[0])
                        mode <= bitsyncModeT'(regReq.wdata[1:0]);
                end
                BS_TOP_CH0_CONTROL:
                    ch0Ctrl <= mergeChan(ch0Ctrl, regReq.wdata, regReq.wstrb);
                BS_TOP_CH1_CONTROL:
                    ch1Ctrl <= mergeChan(ch1Ctrl, regReq.wdata, regReq.wstrb);
                BS_TOP_DC_GAINS: begin
                    if (regReq.wstrb[0])
                        ch0Ctrl.dcGain <= regReq.wdata[4:0];
                    if (regReq.wstrb[1])
                        ch1Ctrl.dcGain <= regReq.wdata[12:8];
                end
                default: ;  // STATUS and unmapped ignore writes
            endcase
        end
    end

    always_comb begin
        rdData = 32'h0;
        if (regReq.rdEn) begin
            case (regReq.addr)
                BS_TOP_CONTROL:
                    rdData = {30'h0, mode};
                BS_TOP_CH0_CONTROL:
                    rdData = chanWord(ch0Ctrl);
                BS_TOP_CH1_CONTROL:
                    rdData = chanWord(ch1Ctrl);
                BS_TOP_STATUS:
                    rdData = {30'h0, lockStatus};   // {ch1, ch0}
                BS_TOP_DC_GAINS:
                    rdData = {16'h0, 3'b0, ch1Ctrl.dcGain, 3'b0, ch0Ctrl.dcGain};
                default:
                    rdData = 32'h0;
            endcase
        end
    end

endmodule

// File: hdl/axiLiteRegBridge.sv
// AXI4-Lite slave, one outstanding write and one outstanding read; responses always OKAY
// A pending write wins over a pending read for the shared register port
`timescale 1ns/1ps

module axiLiteRegBridge (
    input  logic                   busClk,
    input  logic                   rst,
    input  logic                   awValid,
    output logic                   awReady,
    input  logic [12:0]            awAddr,
    input  logic                   wValid,
    output logic                   wReady,
    input  logic [31:0]            wData,
    input  logic [3:0]             wStrb,
    output logic                   bValid,
    input  logic                   bReady,
    output logic [1:0]             bResp,
    input  logic                   arValid,
    output logic                   arReady,
    input  logic [12:0]            arAddr,
    output logic                   rValid,
    input  logic                   rReady,
    output logic [31:0]            rData,
    output logic [1:0]             rResp,
    output bitsyncPkg::regReqT     regReq,
    input  logic [31:0]            rdData
);
    import bitsyncPkg::*;

    logic        awHeld;
    logic        wHeld;
    logic        rdPend;
    logic [12:0] awAddrQ;
    logic [31:0] wDataQ;
    logic [3:0]  wStrbQ;
    logic [12:0] arAddrQ;
    logic        wrGo;
    logic        rdGo;

    // No new address or data until the previous response has gone out
    assign awReady = !awHeld && !bValid;
    assign wReady  = !wHeld && !bValid;
    assign arReady = !rdPend && !rValid;

    assign wrGo = awHeld && wHeld;
    assign rdGo = rdPend && !wrGo;

    assign bResp = 2'b00;
    assign rResp = 2'b00;

    always_comb begin
        regReq = '0;
        if (wrGo) begin
            regReq.wrEn  = 1'b1;
            regReq.addr  = awAddrQ;
            regReq.wdata = wDataQ;
            regReq.wstrb = wStrbQ;
        end else if (rdGo) begin
            regReq.rdEn = 1'b1;
            regReq.addr = arAddrQ;
        end
    end

    always_ff @(posedge busClk) begin
        if (rst) begin
            awHeld  <= 1'b0;
            wHeld   <= 1'b0;
            rdPend  <= 1'b0;
            bValid  <= 1'b0;
            rValid  <= 1'b0;
            awAddrQ <= '0;
            wDataQ  <= '0;
            wStrbQ  <= '0;
            arAddrQ <= '0;
            rData   <= '0;
        end else begin
            if (awValid && awReady) begin
                awHeld  <= 1'b1;
                awAddrQ <= awAddr;
            end
            if (wValid && wReady) begin
                wHeld  <= 1'b1;
                wDataQ <= wData;
                wStrbQ <= wStrb;
            end
            if (wrGo) begin
                awHeld <= 1'b0;
                wHeld  <= 1'b0;
                bValid <= 1'b1;
            end else if (bValid && bReady) begin
                bValid <= 1'b0;
            end

            if (arValid && arReady) begin
                rdPend  <= 1'b1;
                arAddrQ <= arAddr;
            end
            if (rdGo) begin
                rdPend <= 1'b0;
                rValid <= 1'b1;
                rData  <= rdData;   // Held until rReady
            end else if (rValid && rReady) begin
                rValid <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/bitsyncPkg.sv
// Shared types and register map for the bitsync control plane
// Offsets are byte addresses in a 13-bit window; unlisted addresses are unmapped
package bitsyncPkg;

    localparam logic [12:0] BS_TOP_CONTROL     = 13'h000;
    localparam logic [12:0] BS_TOP_CH0_CONTROL = 13'h004;
    localparam logic [12:0] BS_TOP_CH1_CONTROL = 13'h008;
    localparam logic [12:0] BS_TOP_STATUS      = 13'h00C;
    localparam logic [12:0] BS_TOP_DC_GAINS    = 13'h010;

    typedef enum logic [1:0] {
        MODE_OFF  = 2'd0,   // Both channels held unlocked
        MODE_CH0  = 2'd1,
        MODE_CH1  = 2'd2,
        MODE_BOTH = 2'd3
    } bitsyncModeT;

    // Single-cycle access issued by the bus bridge
    typedef struct packed {
        logic        wrEn;
        logic        rdEn;
        logic [12:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } regReqT;

    typedef struct packed {
        logic [3:0] dac0Select;
        logic [3:0] dac1Select;
        logic [3:0] dac2Select;
        logic       dcRemovalEnable;
        logic       highImpedance;
        logic       singleEnded;
        logic [4:0] dcGain;
    } chanCtrlT;

    // Analog front-end settings, forwarded to the pins untouched
    typedef struct packed {
        logic       singleEnded;
        logic       highImpedance;
        logic [4:0] dcGain;
    } afeCtrlT;

    typedef struct packed {
        logic signed [7:0] sample;
        logic signed [7:0] phaseErr;
        logic              locked;
        logic              symbolValid;
    } monitorT;

endpackage
